// File: build.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/decode_stage.sv
design/regfile.sv
design/execute_stage.sv
design/result_stage.sv
design/simple_pipeline.sv
+incdir+testbench
testbench/tb_pipeline.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_pipeline -f build.f
./obj_dir/Vtb_pipeline 2>&1 | tee sim.log
if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

// File: testbench/tb_tests.svh
task automatic test_reset();
  test_name = "reset";
  check_value("commit_wr_en", 64'd0, 64'(commit_wr_en));
  check_value("completed_insts", 64'd0, 64'(completed_insts));
  check_value("error_status", 64'(NO_ERROR), 64'(error_status));
  drain();
endtask

// Each one reads the previous destination
task automatic test_forwarding();
  test_name = "forwarding";
  send(op_lit(OP_INTA, FN_ADDQ, 5'd31, 8'd200, 5'd1));
  send(op_lit(OP_INTA, FN_ADDQ, 5'd1, 8'd55, 5'd2));
  send(op_reg(OP_INTA, FN_ADDQ, 5'd2, 5'd1, 5'd3));
  send(op_reg(OP_INTA, FN_SUBQ, 5'd2, 5'd3, 5'd4));   // Wraps negative
  send(op_reg(OP_INTL, FN_AND, 5'd4, 5'd3, 5'd5));
  send(op_reg(OP_INTL, FN_BIS, 5'd5, 5'd1, 5'd6));
  send(op_reg(OP_INTL, FN_XOR, 5'd6, 5'd4, 5'd7));
  send(op_reg(OP_INTA, FN_CMPEQ, 5'd7, 5'd7, 5'd8));
  send(op_reg(OP_INTA, FN_CMPULT, 5'd8, 5'd7, 5'd9));
  send(op_reg(OP_INTA, FN_CMPULT, 5'd9, 5'd4, 5'd10));
  drain();
endtask

task automatic test_literals();
  test_name = "literals";
  send(op_lit(OP_INTS, FN_SLL, 5'd4, 8'd13, 5'd11));
  send(op_lit(OP_INTS, FN_SRL, 5'd11, 8'd7, 5'd12));
  send(op_lit(OP_INTM, FN_MULQ, 5'd12, 8'd251, 5'd13));
  send(op_reg(OP_INTM, FN_MULQ, 5'd13, 5'd4, 5'd14));
  send(op_lit(OP_INTS, FN_SLL, 5'd14, 8'd63, 5'd15));
  send(op_lit(OP_INTS, FN_SRL, 5'd14, 8'd200, 5'd16));  // Only 6 bits of amount
  send(op_reg(OP_INTS, FN_SLL, 5'd13, 5'd12, 5'd17));
  drain();
endtask

task automatic test_zero_reg();
  test_name = "zero_reg";
  send(op_lit(OP_INTA, FN_ADDQ, 5'd1, 8'd9, 5'd31));
  send(op_reg(OP_INTA, FN_ADDQ, 5'd31, 5'd2, 5'd18));  // R31 is not forwarded
  send(op_reg(OP_INTL, FN_BIS, 5'd31, 5'd31, 5'd19));
  send(NOOP_INST);
  send(op_reg(6'h1b, 7'h00, 5'd1, 5'd2, 5'd20));       // Unknown opcode
  send(op_reg(OP_INTA, 7'h7f, 5'd1, 5'd2, 5'd21));     // Unknown function
  send(op_lit(OP_INTA, FN_ADDQ, 5'd20, 8'd1, 5'd22));
  send(op_lit(OP_INTA, FN_ADDQ, 5'd21, 8'd1, 5'd23));
  drain();
endtask

function automatic logic [31:0] random_inst();
  logic [31:0] r;
  logic [5:0]  op;
  logic [6:0]  fn;
  int          k;
  k = $urandom_range(9, 0);
  r = $urandom;
  case (k)
    0:       {op, fn} = {OP_INTA, FN_ADDQ};
    1:       {op, fn} = {OP_INTA, FN_SUBQ};
    2:       {op, fn} = {OP_INTA, FN_CMPEQ};
    3:       {op, fn} = {OP_INTA, FN_CMPULT};
    4:       {op, fn} = {OP_INTL, FN_AND};
    5:       {op, fn} = {OP_INTL, FN_BIS};
    6:       {op, fn} = {OP_INTL, FN_XOR};
    7:       {op, fn} = {OP_INTS, FN_SLL};
    8:       {op, fn} = {OP_INTS, FN_SRL};
    default: {op, fn} = {OP_INTM, FN_MULQ};
  endcase
  if (r[23])
    return op_lit(op, fn, r[4:0], r[22:15], r[14:10]);
  return op_reg(op, fn, r[4:0], r[9:5], r[14:10]);
endfunction

task automatic test_random();
  test_name = "random";
  repeat (200) send(random_inst());
  drain();
endtask

task automatic test_halt();
  int waited;
  test_name = "halt";
  send(HALT_INST);
  waited = 0;
  while ((error_status != HALTED_ON_HALT) && (waited < 10))
  begin
    send(random_inst());  // Must not commit
    waited++;
  end
  if (error_status != HALTED_ON_HALT)
    report_timeout("error_status never showed the halt");
  repeat (4) send(random_inst());
  drain();
  check_value("error_status", 64'(HALTED_ON_HALT), 64'(error_status));
endtask

// File: testbench/tb_pipeline.sv
`timescale 1ns/100ps

module tb_pipeline import isa_pkg::*, pipe_pkg::*; ();

  // Expected commit for one driven cycle
  typedef struct packed {
    logic        valid;
    logic        wr_en;
    logic        halt;
    logic [4:0]  idx;
    logic [63:0] data;
    logic [63:0] npc;
    logic [31:0] ir;
  } slot_t;

  logic        clock;
  logic        rst_n;
  logic        inst_valid;
  inst_word_u  inst;
  data_t       inst_npc;
  logic        commit_wr_en;
  reg_idx_t    commit_wr_idx;
  data_t       commit_wr_data;
  data_t       commit_npc;
  logic [31:0] commit_ir;
  logic [3:0]  completed_insts;
  status_e     error_status;

  data_t ref_regs [32];  // Architectural state in program order
  slot_t exp_q [$];      // One entry per driven cycle
  data_t next_npc;
  logic  issue_halted;   // Halt already sent
  logic  model_halted;   // Halt already committed
  string test_name;

  simple_pipeline dut0 (
    .clock(clock), .rst_n(rst_n),
    .inst_valid(inst_valid), .inst(inst), .inst_npc(inst_npc),
    .commit_wr_en(commit_wr_en), .commit_wr_idx(commit_wr_idx),
    .commit_wr_data(commit_wr_data), .commit_npc(commit_npc), .commit_ir(commit_ir),
    .completed_insts(completed_insts), .error_status(error_status)
  );

  always #4 clock = ~clock;

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic check_value(input string field, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAIL %s %s expected %h actual %h", test_name, field, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", field);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in test %s: %s", test_name, what);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic check_commit(input slot_t s);
    logic exp_commit;
    logic exp_wr;
    exp_commit = s.valid && !model_halted;  // Nothing commits once halted
    exp_wr     = exp_commit && s.wr_en;
    check_value("completed_insts", 64'(exp_commit), 64'(completed_insts));
    check_value("commit_wr_en", 64'(exp_wr), 64'(commit_wr_en));
    if (exp_commit)
    begin
      check_value("commit_wr_idx", 64'(s.idx), 64'(commit_wr_idx));
      check_value("commit_npc", s.npc, commit_npc);
      check_value("commit_ir", 64'(s.ir), 64'(commit_ir));
      if (exp_wr)
        check_value("commit_wr_data", s.data, commit_wr_data);
      if (s.halt)
        model_halted = 1'b1;
    end
    check_value("error_status", 64'(model_halted ? HALTED_ON_HALT : NO_ERROR),
                64'(error_status));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  task automatic issue_model(input logic valid, input logic [31:0] word,
                             input data_t npc, output slot_t s);
    inst_word_u w;
    data_t      a;
    data_t      b;
    logic       known;
    w      = word;
    a      = ref_regs[w.rv.ra];
    b      = w.rv.lit_flag ? {56'b0, w.lv.lit} : ref_regs[w.rv.rb];
    known  = 1'b1;
    s.data = '0;
    case ({w.rv.opcode, w.rv.func})
      {OP_INTA, FN_ADDQ}:   s.data = a + b;
      {OP_INTA, FN_SUBQ}:   s.data = a - b;
      {OP_INTA, FN_CMPEQ}:  s.data = {63'b0, a == b};
      {OP_INTA, FN_CMPULT}: s.data = {63'b0, a < b};
      {OP_INTL, FN_AND}:    s.data = a & b;
      {OP_INTL, FN_BIS}:    s.data = a | b;
      {OP_INTL, FN_XOR}:    s.data = a ^ b;
      {OP_INTS, FN_SLL}:    s.data = a << b[5:0];
      {OP_INTS, FN_SRL}:    s.data = a >> b[5:0];
      {OP_INTM, FN_MULQ}:   s.data = a * b;
      default:              known = 1'b0;
    endcase
    s.valid = valid;
    s.halt  = valid && (word == HALT_INST);
    s.idx   = known ? w.rv.rc : ZERO_REG;
    s.wr_en = known && (w.rv.rc != ZERO_REG);
    s.npc   = npc;
    s.ir    = word;
    if (valid && s.wr_en && !issue_halted)
      ref_regs[w.rv.rc] = s.data;
    if (s.halt)
      issue_halted = 1'b1;
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Checks the cycle driven three falling edges ago, then drives this one
  task automatic step(input logic valid, input logic [31:0] word, input data_t npc);
    slot_t s;
    @(negedge clock);
    if (exp_q.size() == 3)
    begin
      s = exp_q.pop_front();
      check_commit(s);
    end
    issue_model(valid, word, npc, s);
    inst_valid = valid;
    inst       = word;
    inst_npc   = npc;
    exp_q.push_back(s);
  endtask

  task automatic send(input logic [31:0] word);
    step(1'b1, word, next_npc);
    next_npc = next_npc + 64'd4;
  endtask

  task automatic drain();
    repeat (3) step(1'b0, NOOP_INST, '0);  // Bubbles flush the pipe
  endtask

  function automatic logic [31:0] op_reg(input logic [5:0] op, input logic [6:0] fn,
                                         input logic [4:0] ra, input logic [4:0] rb,
                                         input logic [4:0] rc);
    return {op, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  function automatic logic [31:0] op_lit(input logic [5:0] op, input logic [6:0] fn,
                                         input logic [4:0] ra, input logic [7:0] lit,
                                         input logic [4:0] rc);
    return {op, ra, lit, 1'b1, fn, rc};
  endfunction

  `include "tb_tests.svh"

  initial
  begin
    void'($urandom(32'haf73));
    clock        = 1'b0;
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst         = NOOP_INST;
    inst_npc     = '0;
    next_npc     = 64'h1_0000;
    issue_halted = 1'b0;
    model_halted = 1'b0;
    test_name    = "setup";
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    test_reset();
    test_forwarding();
    test_literals();
    test_zero_reg();
    test_random();
    test_halt();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: design/simple_pipeline.sv
`timescale 1ns/100ps

module simple_pipeline import isa_pkg::*, pipe_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        inst_valid,
  input  inst_word_u  inst,
  input  data_t       inst_npc,
  output logic        commit_wr_en,
  output reg_idx_t    commit_wr_idx,
  output data_t       commit_wr_data,
  output data_t       commit_npc,
  output logic [31:0] commit_ir,
  output logic [3:0]  completed_insts,
  output status_e     error_status
);

  // Decode register
  logic        dec_valid;
  alu_op_e     dec_op;
  reg_idx_t    dec_ra;
  reg_idx_t    dec_rb;
  reg_idx_t    dec_dest;
  logic        dec_use_lit;
  logic [7:0]  dec_lit;
  logic        dec_halt;
  data_t       dec_npc;
  logic [31:0] dec_ir;

  // Register file ports
  reg_idx_t rda_idx;
  reg_idx_t rdb_idx;
  data_t    rda_data;
  data_t    rdb_data;
  logic     wr_en;
  reg_idx_t wr_idx;
  data_t    wr_data;

  // Execute register
  logic        ex_valid;
  reg_idx_t    ex_dest;
  data_t       ex_result;
  logic        ex_halt;
  data_t       ex_npc;
  logic [31:0] ex_ir;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  decode_stage decode0 (
    .clock(clock), .rst_n(rst_n),
    .inst_valid(inst_valid), .inst(inst), .inst_npc(inst_npc),
    .dec_valid(dec_valid), .dec_op(dec_op), .dec_ra(dec_ra), .dec_rb(dec_rb),
    .dec_dest(dec_dest), .dec_use_lit(dec_use_lit), .dec_lit(dec_lit),
    .dec_halt(dec_halt), .dec_npc(dec_npc), .dec_ir(dec_ir)
  );

  regfile regs0 (
    .clock(clock), .rst_n(rst_n),
    .rda_idx(rda_idx), .rdb_idx(rdb_idx), .rda_data(rda_data), .rdb_data(rdb_data),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
  );

  execute_stage ex0 (
    .clock(clock), .rst_n(rst_n),
    .dec_valid(dec_valid), .dec_op(dec_op), .dec_ra(dec_ra), .dec_rb(dec_rb),
    .dec_dest(dec_dest), .dec_use_lit(dec_use_lit), .dec_lit(dec_lit),
    .dec_halt(dec_halt), .dec_npc(dec_npc), .dec_ir(dec_ir),
    .rda_idx(rda_idx), .rdb_idx(rdb_idx), .rda_data(rda_data), .rdb_data(rdb_data),
    .ex_valid(ex_valid), .ex_dest(ex_dest), .ex_result(ex_result),
    .ex_halt(ex_halt), .ex_npc(ex_npc), .ex_ir(ex_ir)
  );

  result_stage result0 (
    .clock(clock), .rst_n(rst_n),
    .ex_valid(ex_valid), .ex_dest(ex_dest), .ex_result(ex_result),
    .ex_halt(ex_halt), .ex_npc(ex_npc), .ex_ir(ex_ir),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .commit_wr_en(commit_wr_en), .commit_wr_idx(commit_wr_idx),
    .commit_wr_data(commit_wr_data), .commit_npc(commit_npc), .commit_ir(commit_ir),
    .completed_insts(completed_insts), .error_status(error_status)
  );

endmodule

// File: design/result_stage.sv
`timescale 1ns/100ps

module result_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        ex_valid,
  input  reg_idx_t    ex_dest,
  input  data_t       ex_result,
  input  logic        ex_halt,
  input  data_t       ex_npc,
  input  logic [31:0] ex_ir,
  output logic        wr_en,
  output reg_idx_t    wr_idx,
  output data_t       wr_data,
  output logic        commit_wr_en,
  output reg_idx_t    commit_wr_idx,
  output data_t       commit_wr_data,
  output data_t       commit_npc,
  output logic [31:0] commit_ir,
  output logic [3:0]  completed_insts,
  output status_e     error_status
);

  logic halted;       // Sticky until reset
  logic commit_now;

  assign commit_now = ex_valid && !halted;

  ////////////////////////////////////////
  // Register file write back
  ////////////////////////////////////////

  assign wr_en   = commit_now && (ex_dest != ZERO_REG);
  assign wr_idx  = ex_dest;
  assign wr_data = ex_result;

  ////////////////////////////////////////
  // Commit outputs
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      commit_wr_en    <= 1'b0;
      completed_insts <= 4'd0;
      halted          <= 1'b0;
    end
    else
    begin
      commit_wr_en    <= wr_en;
      completed_insts <= commit_now ? 4'd1 : 4'd0;
      if (commit_now && ex_halt)
        halted <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    commit_wr_idx  <= ex_dest;
    commit_wr_data <= ex_result;
    commit_npc     <= ex_npc;
    commit_ir      <= ex_ir;
  end

  // Status follows the halted flag in the same cycle
  assign error_status = halted ? HALTED_ON_HALT : NO_ERROR;

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage import isa_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        dec_valid,
  input  alu_op_e     dec_op,
  input  reg_idx_t    dec_ra,
  input  reg_idx_t    dec_rb,
  input  reg_idx_t    dec_dest,
  input  logic        dec_use_lit,
  input  logic [7:0]  dec_lit,
  input  logic        dec_halt,
  input  data_t       dec_npc,
  input  logic [31:0] dec_ir,
  output reg_idx_t    rda_idx,
  output reg_idx_t    rdb_idx,
  input  data_t       rda_data,
  input  data_t       rdb_data,
  output logic        ex_valid,
  output reg_idx_t    ex_dest,
  output data_t       ex_result,
  output logic        ex_halt,
  output data_t       ex_npc,
  output logic [31:0] ex_ir
);

  logic  fwd_a;
  logic  fwd_b;
  data_t opa;
  data_t opb;
  data_t reg_b;
  data_t alu_out;

  assign rda_idx = dec_ra;
  assign rdb_idx = dec_rb;

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////

  // Only the instruction one ahead is still unwritten
  assign fwd_a = ex_valid && (ex_dest == dec_ra) && !(&dec_ra);
  assign fwd_b = ex_valid && (ex_dest == dec_rb) && !(&dec_rb);

  assign opa   = fwd_a ? ex_result : rda_data;
  assign reg_b = fwd_b ? ex_result : rdb_data;
  assign opb   = dec_use_lit ? {56'b0, dec_lit} : reg_b;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb
  begin
    case (dec_op)
      ALU_ADD:    alu_out = opa + opb;
      ALU_SUB:    alu_out = opa - opb;
      ALU_CMPEQ:  alu_out = {63'b0, opa == opb};
      ALU_CMPULT: alu_out = {63'b0, opa < opb};  // Unsigned compare
      ALU_AND:    alu_out = opa & opb;
      ALU_OR:     alu_out = opa | opb;
      ALU_XOR:    alu_out = opa ^ opb;
      ALU_SLL:    alu_out = opa << opb[5:0];
      ALU_SRL:    alu_out = opa >> opb[5:0];
      ALU_MUL:    alu_out = opa * opb;      // Low half of the product
      default:    alu_out = '0;
    endcase
  end

  // Execute pipeline register
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_valid <= 1'b0;
      ex_halt  <= 1'b0;
    end
    else
    begin
      ex_valid <= dec_valid;
      ex_halt  <= dec_valid & dec_halt;
    end
  end

  always_ff @(posedge clock)
  begin
    ex_dest   <= dec_dest;
    ex_result <= alu_out;
    ex_npc    <= dec_npc;
    ex_ir     <= dec_ir;
  end

endmodule

// File: design/regfile.sv
`timescale 1ns/100ps

module regfile import isa_pkg::*; (
  input  logic     clock,
  input  logic     rst_n,
  input  reg_idx_t rda_idx,
  input  reg_idx_t rdb_idx,
  output data_t    rda_data,
  output data_t    rdb_data,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  data_t    wr_data
);

  data_t regs [32];

  // Write port
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
    begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Read ports, R31 is the all-ones index and always reads zero
  assign rda_data = (&rda_idx) ? '0 : regs[rda_idx];
  assign rdb_data = (&rdb_idx) ? '0 : regs[rdb_idx];

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        inst_valid,
  input  inst_word_u  inst,
  input  data_t       inst_npc,
  output logic        dec_valid,
  output alu_op_e     dec_op,
  output reg_idx_t    dec_ra,
  output reg_idx_t    dec_rb,
  output reg_idx_t    dec_dest,
  output logic        dec_use_lit,
  output logic [7:0]  dec_lit,
  output logic        dec_halt,
  output data_t       dec_npc,
  output logic [31:0] dec_ir
);

  alu_op_e    op_d;
  logic       known;      // Recognized operate instruction
  logic       halt_d;
  reg_idx_t   rb_d;
  logic [7:0] lit_d;

  ////////////////////////////////////////
  // Opcode and function decode
  ////////////////////////////////////////

  always_comb
  begin
    op_d   = ALU_ADD;
    known  = 1'b1;
    halt_d = 1'b0;
    case (inst.rv.opcode)
      OP_INTA:
        case (inst.rv.func)
          FN_ADDQ:   op_d = ALU_ADD;
          FN_SUBQ:   op_d = ALU_SUB;
          FN_CMPEQ:  op_d = ALU_CMPEQ;
          FN_CMPULT: op_d = ALU_CMPULT;
          default:   known = 1'b0;
        endcase
      OP_INTL:
        case (inst.rv.func)
          FN_AND:  op_d = ALU_AND;
          FN_BIS:  op_d = ALU_OR;
          FN_XOR:  op_d = ALU_XOR;
          default: known = 1'b0;
        endcase
      OP_INTS:
        case (inst.rv.func)
          FN_SLL:  op_d = ALU_SLL;
          FN_SRL:  op_d = ALU_SRL;
          default: known = 1'b0;
        endcase
      OP_INTM:
        if (inst.rv.func != FN_MULQ)
          known = 1'b0;
        else
          op_d = ALU_MUL;
      OP_PAL:
      begin
        known  = 1'b0;
        halt_d = (inst == HALT_INST);
      end
      default: known = 1'b0;  // Passes through as a no-op
    endcase
  end

  // Literal flag selects which view supplies operand B
  always_comb
  begin
    if (inst.rv.lit_flag)
    begin
      rb_d  = ZERO_REG;
      lit_d = inst.lv.lit;
    end
    else
    begin
      rb_d  = inst.rv.rb;
      lit_d = '0;
    end
  end

  ////////////////////////////////////////
  // Decode pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dec_valid <= 1'b0;
      dec_halt  <= 1'b0;
      dec_ir    <= NOOP_INST;
    end
    else
    begin
      dec_valid <= inst_valid;
      dec_halt  <= inst_valid & halt_d;
      dec_ir    <= inst;
    end
  end

  always_ff @(posedge clock)
  begin
    dec_op      <= op_d;
    dec_ra      <= inst.rv.ra;
    dec_rb      <= rb_d;
    dec_dest    <= known ? inst.rv.rc : ZERO_REG;  // Halt and unknown write nothing
    dec_use_lit <= inst.rv.lit_flag;
    dec_lit     <= lit_d;
    dec_npc     <= inst_npc;
  end

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

  ////////////////////////////////////////
  // Registers and special words
  ////////////////////////////////////////

  localparam logic [4:0] ZERO_REG = 5'd31;  // R31 always reads as zero

  // BIS R31,R31,R31
  localparam logic [31:0] NOOP_INST = 32'h47ff041f;

  // CALL_PAL with the halt function
  localparam logic [31:0] HALT_INST = 32'h555;

  ////////////////////////////////////////
  // Pipeline status
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    NO_ERROR       = 4'h0,
    HALTED_ON_HALT = 4'h2
  } status_e;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////
  // Basic word types
  ////////////////////////////////////////

  typedef logic [63:0] data_t;     // One register value
  typedef logic [4:0]  reg_idx_t;  // Architectural register number

  // Operate-format word, seen two ways. Bit 12 picks the view
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      reg_idx_t   ra;
      reg_idx_t   rb;
      logic [2:0] unused;     // Should be zero
      logic       lit_flag;
      logic [6:0] func;
      reg_idx_t   rc;
    } rv;
    struct packed {
      logic [5:0] opcode;
      reg_idx_t   ra;
      logic [7:0] lit;        // Zero-extended literal
      logic       lit_flag;
      logic [6:0] func;
      reg_idx_t   rc;
    } lv;
  } inst_word_u;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  localparam logic [5:0] OP_PAL  = 6'h00;
  localparam logic [5:0] OP_INTA = 6'h10;  // Arithmetic and compares
  localparam logic [5:0] OP_INTL = 6'h11;  // Logical
  localparam logic [5:0] OP_INTS = 6'h12;  // Shifts
  localparam logic [5:0] OP_INTM = 6'h13;  // Multiply

  // Function codes, only meaningful together with the opcode
  localparam logic [6:0] FN_ADDQ   = 7'h20;
  localparam logic [6:0] FN_SUBQ   = 7'h29;
  localparam logic [6:0] FN_CMPEQ  = 7'h2d;
  localparam logic [6:0] FN_CMPULT = 7'h1d;
  localparam logic [6:0] FN_AND    = 7'h00;
  localparam logic [6:0] FN_BIS    = 7'h20;
  localparam logic [6:0] FN_XOR    = 7'h40;
  localparam logic [6:0] FN_SLL    = 7'h39;
  localparam logic [6:0] FN_SRL    = 7'h34;
  localparam logic [6:0] FN_MULQ   = 7'h20;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_CMPEQ  = 4'd2,
    ALU_CMPULT = 4'd3,
    ALU_AND    = 4'd4,
    ALU_OR     = 4'd5,
    ALU_XOR    = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_MUL    = 4'd9
  } alu_op_e;

endpackage
